//--- Makefile
# Verilator build and run for the fetch stage testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_stage
FILELIST  ?= fetch_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST))) source/fetch_cfg.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- fetch_stage.f
+incdir+source
source/fetch_pkg.sv
source/fetch_pc_mux.sv
source/fetch_trap_regs.sv
source/fetch_prefetch.sv
source/fetch_if_id_reg.sv
source/fetch_stage.sv
tests/tb_fetch_stage.sv

//--- source/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Data and byte address width
`define FETCH_XLEN 32

// Upper bits of the trap vector kept in the base register
`define FETCH_MTVEC_BASE_W 25

// Interrupt index width for vectored traps
`define FETCH_IRQ_ID_W 5

// Response FIFO entries, also the cap on requests in flight
`define FETCH_FIFO_DEPTH 2

// Outstanding, drop and fill counters
`define FETCH_CNT_W 2

// Trap register reset values
`define FETCH_MTVEC_RST 25'h000_0000
`define FETCH_MEPC_RST 32'h0000_0000

`endif

//--- source/fetch_if_id_reg.sv
`default_nettype none
`timescale 1ns/1ns

module fetch_if_id_reg (
  input  wire                    clk,
  input  wire                    rst_n,
  input  fetch_pkg::fetch_ctrl_t ctrl_i,
  input  wire                    id_ready_i,
  input  wire                    fifo_valid_i,
  input  fetch_pkg::fetch_resp_t fifo_head_i,
  input  fetch_pkg::addr_t       fifo_pc_i,
  output logic                   pop_o,
  output logic                   if_valid_o,
  output fetch_pkg::if_id_t      if_id_o
);

  logic                   accept;
  logic                   valid_q;
  fetch_pkg::addr_t       pc_q;
  fetch_pkg::instr_word_t instr_q;
  logic                   compressed_q;
  logic                   bus_err_q;

  ////////////////////////////////////////////////////////////
  // IF handshake
  ////////////////////////////////////////////////////////////

  // Kill and halt both hide the head from ID
  assign if_valid_o = fifo_valid_i && !ctrl_i.kill_if && !ctrl_i.halt_if;
  // Kill discards the head, halt keeps it
  assign pop_o  = fifo_valid_i && (ctrl_i.kill_if || (id_ready_i && !ctrl_i.halt_if));
  assign accept = if_valid_o && id_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (id_ready_i) begin
      // ID took the old one, nothing new behind it
      valid_q <= 1'b0;
    end
  end

  // Frozen while ID stalls
  always_ff @(posedge clk) begin
    if (accept) begin
      pc_q         <= fifo_pc_i;
      instr_q      <= fifo_head_i.rdata;
      compressed_q <= (fifo_head_i.rdata[1:0] != 2'b11);
      bus_err_q    <= fifo_head_i.err;
    end
  end

  assign if_id_o = '{valid: valid_q, pc: pc_q, instr: instr_q,
                     compressed: compressed_q, bus_err: bus_err_q};

endmodule

`default_nettype wire

//--- source/fetch_pc_mux.sv
`default_nettype none
`timescale 1ns/1ns

module fetch_pc_mux (
  input  fetch_pkg::fetch_ctrl_t ctrl_i,
  input  fetch_pkg::addr_t       boot_addr_i,
  input  fetch_pkg::addr_t       jump_target_i,
  input  fetch_pkg::addr_t       branch_target_i,
  input  fetch_pkg::mtvec_base_t mtvec_base_i,
  input  fetch_pkg::addr_t       mepc_i,
  output fetch_pkg::addr_t       next_pc_o
);

  ////////////////////////////////////////////////////////////
  // Redirect target selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (ctrl_i.pc_mux)
      fetch_pkg::PC_BOOT: begin
        next_pc_o = {boot_addr_i[31:2], 2'b00};
      end
      fetch_pkg::PC_JUMP: begin
        next_pc_o = jump_target_i;
      end
      fetch_pkg::PC_BRANCH: begin
        next_pc_o = branch_target_i;
      end
      // Return to the saved PC, word aligned
      fetch_pkg::PC_MRET: begin
        next_pc_o = {mepc_i[31:2], 2'b00};
      end
      // All exceptions share the vector base
      fetch_pkg::PC_TRAP_EXC: begin
        next_pc_o = {mtvec_base_i, 7'h00};
      end
      // Interrupts vector by index, one word per entry
      fetch_pkg::PC_TRAP_IRQ: begin
        next_pc_o = {mtvec_base_i, ctrl_i.irq_id, 2'b00};
      end
      // Unused encodings fall back to the boot target
      default: begin
        next_pc_o = {boot_addr_i[31:2], 2'b00};
      end
    endcase
  end

endmodule

`default_nettype wire

//--- source/fetch_pkg.sv
`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

  // Widths with a meaning of their own
  typedef logic [`FETCH_XLEN-1:0]         addr_t;
  typedef logic [`FETCH_XLEN-1:0]         instr_word_t;
  typedef logic [`FETCH_MTVEC_BASE_W-1:0] mtvec_base_t;
  typedef logic [`FETCH_IRQ_ID_W-1:0]     irq_id_t;
  typedef logic [`FETCH_CNT_W-1:0]        fifo_cnt_t;

  // Redirect cause
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_mux_e;

  // Trap register select for CSR writes
  typedef enum logic [0:0] {
    CSR_MTVEC = 1'b0,
    CSR_MEPC  = 1'b1
  } csr_sel_e;

  // Controller to IF
  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
    irq_id_t irq_id;
    logic    kill_if;
    logic    halt_if;
  } fetch_ctrl_t;

  typedef struct packed {
    logic     we;
    csr_sel_e sel;
    addr_t    wdata;
  } csr_wr_t;

  // One buffered bus response
  typedef struct packed {
    instr_word_t rdata;
    logic        err;
  } fetch_resp_t;

  // IF/ID pipeline contents
  typedef struct packed {
    logic        valid;
    addr_t       pc;
    instr_word_t instr;
    logic        compressed;
    logic        bus_err;
  } if_id_t;

endpackage

`default_nettype wire

//--- source/fetch_prefetch.sv
`default_nettype none
`timescale 1ns/1ns

`include "fetch_cfg.svh"

module fetch_prefetch (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    pc_set_i,
  input  fetch_pkg::addr_t       next_pc_i,
  input  wire                    pop_i,
  output logic                   instr_req_o,
  output fetch_pkg::addr_t       instr_addr_o,
  input  wire                    instr_gnt_i,
  input  wire                    instr_rvalid_i,
  input  fetch_pkg::instr_word_t instr_rdata_i,
  input  wire                    instr_err_i,
  output logic                   fifo_valid_o,
  output fetch_pkg::fetch_resp_t fifo_head_o,
  output fetch_pkg::addr_t       fifo_pc_o
);

  // FIFO pointer width, one bit per doubling of the depth
  localparam int PTR_W = $clog2(`FETCH_FIFO_DEPTH);

  fetch_pkg::addr_t       fetch_addr_q;
  fetch_pkg::addr_t       head_pc_q;
  logic                   fetch_en_q;
  fetch_pkg::fifo_cnt_t   outst_q;
  fetch_pkg::fifo_cnt_t   outst_n;
  fetch_pkg::fifo_cnt_t   drop_q;
  fetch_pkg::fifo_cnt_t   fill_q;
  logic [PTR_W-1:0]       wptr_q;
  logic [PTR_W-1:0]       rptr_q;
  logic [`FETCH_CNT_W:0]  in_flight;
  logic                   grant;
  logic                   wr_en;
  logic                   rd_en;
  fetch_pkg::fetch_resp_t mem_q [0:`FETCH_FIFO_DEPTH-1];

  // Wrap a FIFO pointer at the depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`FETCH_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  ////////////////////////////////////////////////////////////
  // Bus request side
  ////////////////////////////////////////////////////////////

  // Requests in flight plus buffered words must leave room
  assign in_flight    = {1'b0, outst_q} + {1'b0, fill_q};
  assign instr_req_o  = fetch_en_q && (in_flight < `FETCH_FIFO_DEPTH);
  assign instr_addr_o = fetch_addr_q;
  assign grant        = instr_req_o && instr_gnt_i;

  // Stale responses include one granted in the redirect cycle
  assign outst_n = outst_q + fetch_pkg::fifo_cnt_t'(grant)
                 - fetch_pkg::fifo_cnt_t'(instr_rvalid_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_en_q   <= 1'b0;
      fetch_addr_q <= '0;
      outst_q      <= '0;
      drop_q       <= '0;
    end else begin
      outst_q <= outst_n;
      // Idle until the first redirect
      if (pc_set_i) begin
        fetch_en_q   <= 1'b1;
        fetch_addr_q <= next_pc_i;
        drop_q       <= outst_n;
      end else begin
        if (grant) begin
          fetch_addr_q <= fetch_addr_q + fetch_pkg::addr_t'(4);
        end
        if (instr_rvalid_i && (drop_q != '0)) begin
          drop_q <= drop_q - fetch_pkg::fifo_cnt_t'(1);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Response FIFO
  ////////////////////////////////////////////////////////////

  assign wr_en = instr_rvalid_i && !pc_set_i && (drop_q == '0);
  assign rd_en = pop_i && fifo_valid_o && !pc_set_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr_q    <= '0;
      rptr_q    <= '0;
      fill_q    <= '0;
      head_pc_q <= '0;
    end else if (pc_set_i) begin
      // Flush, head PC restarts at the target
      wptr_q    <= '0;
      rptr_q    <= '0;
      fill_q    <= '0;
      head_pc_q <= next_pc_i;
    end else begin
      if (wr_en) begin
        wptr_q <= ptr_inc(wptr_q);
      end
      if (rd_en) begin
        rptr_q    <= ptr_inc(rptr_q);
        head_pc_q <= head_pc_q + fetch_pkg::addr_t'(4);
      end
      fill_q <= fill_q + fetch_pkg::fifo_cnt_t'(wr_en) - fetch_pkg::fifo_cnt_t'(rd_en);
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_q[wptr_q] <= '{rdata: instr_rdata_i, err: instr_err_i};
    end
  end

  assign fifo_valid_o = (fill_q != '0);
  assign fifo_head_o  = mem_q[rptr_q];
  assign fifo_pc_o    = head_pc_q;

endmodule

`default_nettype wire

//--- source/fetch_stage.sv
`default_nettype none
`timescale 1ns/1ns

module fetch_stage (
  input  wire                    clk,
  input  wire                    rst_n,
  input  fetch_pkg::fetch_ctrl_t ctrl_i,
  input  fetch_pkg::csr_wr_t     csr_wr_i,
  input  fetch_pkg::addr_t       boot_addr_i,
  input  fetch_pkg::addr_t       jump_target_i,
  input  fetch_pkg::addr_t       branch_target_i,
  input  wire                    id_ready_i,
  // Instruction bus
  output logic                   instr_req_o,
  output fetch_pkg::addr_t       instr_addr_o,
  input  wire                    instr_gnt_i,
  input  wire                    instr_rvalid_i,
  input  fetch_pkg::instr_word_t instr_rdata_i,
  input  wire                    instr_err_i,
  // To ID
  output logic                   if_valid_o,
  output fetch_pkg::if_id_t      if_id_o
);

  fetch_pkg::mtvec_base_t mtvec_base;
  fetch_pkg::addr_t       mepc;
  fetch_pkg::addr_t       next_pc;
  logic                   fifo_valid;
  fetch_pkg::fetch_resp_t fifo_head;
  fetch_pkg::addr_t       fifo_pc;
  logic                   pop;

  // Trap registers feed the PC mux
  fetch_trap_regs u_trap_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_wr_i     (csr_wr_i),
    .ctrl_i       (ctrl_i),
    .boot_addr_i  (boot_addr_i),
    .mtvec_base_o (mtvec_base),
    .mepc_o       (mepc)
  );

  fetch_pc_mux u_pc_mux (
    .ctrl_i          (ctrl_i),
    .boot_addr_i     (boot_addr_i),
    .jump_target_i   (jump_target_i),
    .branch_target_i (branch_target_i),
    .mtvec_base_i    (mtvec_base),
    .mepc_i          (mepc),
    .next_pc_o       (next_pc)
  );

  fetch_prefetch u_prefetch (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (ctrl_i.pc_set),
    .next_pc_i      (next_pc),
    .pop_i          (pop),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .fifo_valid_o   (fifo_valid),
    .fifo_head_o    (fifo_head),
    .fifo_pc_o      (fifo_pc)
  );

  // Pop goes back to the FIFO
  fetch_if_id_reg u_if_id_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl_i),
    .id_ready_i   (id_ready_i),
    .fifo_valid_i (fifo_valid),
    .fifo_head_i  (fifo_head),
    .fifo_pc_i    (fifo_pc),
    .pop_o        (pop),
    .if_valid_o   (if_valid_o),
    .if_id_o      (if_id_o)
  );

endmodule

`default_nettype wire

//--- source/fetch_trap_regs.sv
`default_nettype none
`timescale 1ns/1ns

`include "fetch_cfg.svh"

module fetch_trap_regs (
  input  wire                    clk,
  input  wire                    rst_n,
  input  fetch_pkg::csr_wr_t     csr_wr_i,
  input  fetch_pkg::fetch_ctrl_t ctrl_i,
  input  fetch_pkg::addr_t       boot_addr_i,
  output fetch_pkg::mtvec_base_t mtvec_base_o,
  output fetch_pkg::addr_t       mepc_o
);

  fetch_pkg::mtvec_base_t mtvec_base_q;
  fetch_pkg::addr_t       mepc_q;
  logic                   boot_redirect;

  // Boot redirect reloads the vector base
  assign boot_redirect = ctrl_i.pc_set && (ctrl_i.pc_mux == fetch_pkg::PC_BOOT);

  ////////////////////////////////////////////////////////////
  // Trap vector base
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mtvec_base_q <= `FETCH_MTVEC_RST;
    end else if (boot_redirect) begin
      // Boot wins over a CSR write in the same cycle
      mtvec_base_q <= boot_addr_i[31:7];
    end else if (csr_wr_i.we && (csr_wr_i.sel == fetch_pkg::CSR_MTVEC)) begin
      mtvec_base_q <= csr_wr_i.wdata[31:7];
    end
  end

  // Exception return PC
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mepc_q <= `FETCH_MEPC_RST;
    end else if (csr_wr_i.we && (csr_wr_i.sel == fetch_pkg::CSR_MEPC)) begin
      mepc_q <= csr_wr_i.wdata;
    end
  end

  assign mtvec_base_o = mtvec_base_q;
  assign mepc_o       = mepc_q;

endmodule

`default_nettype wire

//--- tests/tb_fetch_stage.sv
`default_nettype none
`timescale 1ns/1ns

`include "fetch_cfg.svh"

module tb_fetch_stage;

  localparam int CLK_PERIOD   = 100;
  localparam int PHASES       = 6;
  localparam int PHASE_CYCLES = 600;
  localparam int WAIT_CYCLES  = 300;

  logic                   clk;
  logic                   rst_n;
  fetch_pkg::fetch_ctrl_t ctrl_i;
  fetch_pkg::csr_wr_t     csr_wr_i;
  fetch_pkg::addr_t       boot_addr_i;
  fetch_pkg::addr_t       jump_target_i;
  fetch_pkg::addr_t       branch_target_i;
  logic                   id_ready_i;
  logic                   instr_req_o;
  fetch_pkg::addr_t       instr_addr_o;
  logic                   instr_gnt_i;
  logic                   instr_rvalid_i;
  fetch_pkg::instr_word_t instr_rdata_i;
  logic                   instr_err_i;
  logic                   if_valid_o;
  fetch_pkg::if_id_t      if_id_o;

  // Memory model and reference model state
  fetch_pkg::addr_t       pend_addr[$];
  int                     pend_due[$];
  int                     cycle_cnt = 0;
  int                     delivered = 0;
  int                     stale     = 0;
  int                     buffered  = 0;
  logic [31:0]            bus_seed  = 32'h4604;
  logic [31:0]            stim_seed = 32'h4604;
  logic                   started   = 1'b0;
  logic                   check_pending = 1'b0;
  logic                   last_ready = 1'b0;
  fetch_pkg::if_id_t      last_if_id;
  fetch_pkg::addr_t       exp_pc    = '0;
  fetch_pkg::addr_t       chk_pc    = '0;
  fetch_pkg::mtvec_base_t sh_mtvec  = `FETCH_MTVEC_RST;
  fetch_pkg::addr_t       sh_mepc   = `FETCH_MEPC_RST;

  fetch_stage u_fetch_stage (
    .clk (clk), .rst_n (rst_n), .ctrl_i (ctrl_i), .csr_wr_i (csr_wr_i),
    .boot_addr_i (boot_addr_i), .jump_target_i (jump_target_i),
    .branch_target_i (branch_target_i), .id_ready_i (id_ready_i),
    .instr_req_o (instr_req_o), .instr_addr_o (instr_addr_o),
    .instr_gnt_i (instr_gnt_i), .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i), .instr_err_i (instr_err_i),
    .if_valid_o (if_valid_o), .if_id_o (if_id_o)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Word contents, odd words carry a full-width opcode
  function automatic fetch_pkg::instr_word_t mem_word(input fetch_pkg::addr_t a);
    fetch_pkg::instr_word_t w;
    w = a ^ 32'h5A5A_0000;
    if (a[2]) begin
      w[1:0] = 2'b11;
    end
    return w;
  endfunction

  // Bus error window
  function automatic logic mem_err(input fetch_pkg::addr_t a);
    return (a >= 32'h0000_2040) && (a < 32'h0000_2060);
  endfunction

  // Expected redirect target from the current trap state
  function automatic fetch_pkg::addr_t ref_target(input fetch_pkg::fetch_ctrl_t c);
    case (c.pc_mux)
      fetch_pkg::PC_BOOT:     return {boot_addr_i[31:2], 2'b00};
      fetch_pkg::PC_JUMP:     return jump_target_i;
      fetch_pkg::PC_BRANCH:   return branch_target_i;
      fetch_pkg::PC_MRET:     return {sh_mepc[31:2], 2'b00};
      fetch_pkg::PC_TRAP_EXC: return {sh_mtvec, 7'h00};
      default:                return {sh_mtvec, c.irq_id, 2'b00};
    endcase
  endfunction

  function automatic string mismatch(input string msg);
    return $sformatf("MISMATCH at %0t ns: %s", $time, msg);
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  ////////////////////////////////////////////////////////////
  // Clock, watchdog and bus responder
  ////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(PHASES * PHASE_CYCLES * CLK_PERIOD);
    stop_run("Watchdog expired before all test phases completed");
  end

  // Random grant, in-order responses once due
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    #10;
    bus_seed    = lcg_next(bus_seed);
    instr_gnt_i = (bus_seed[31:30] != 2'b00);
    if ((pend_due.size() > 0) && (pend_due[0] <= cycle_cnt)) begin
      instr_rdata_i  = mem_word(pend_addr[0]);
      instr_err_i    = mem_err(pend_addr[0]);
      instr_rvalid_i = 1'b1;
      void'(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end else begin
      instr_rvalid_i = 1'b0;
      instr_rdata_i  = '0;
      instr_err_i    = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Monitor and reference model, sampled mid-cycle
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    fetch_pkg::instr_word_t exp_instr;
    // Grant seen now is taken at the next edge, response 1 to 3 cycles later
    if (rst_n && instr_req_o && instr_gnt_i) begin
      pend_addr.push_back(instr_addr_o);
      pend_due.push_back(cycle_cnt + 1 + int'(bus_seed[13:8]) % 3);
    end
    if (!started) begin
      assert (!instr_req_o && !if_valid_o && !if_id_o.valid)
        else stop_run(mismatch("fetch activity before the first redirect"));
    end
    // IF valid follows the buffered count, hidden by kill and halt
    assert (if_valid_o == ((buffered > 0) && !ctrl_i.kill_if && !ctrl_i.halt_if))
      else stop_run(mismatch($sformatf("if_valid %b with %0d words buffered",
                                       if_valid_o, buffered)));
    // Entry accepted in the previous cycle
    if (check_pending) begin
      exp_instr = mem_word(chk_pc);
      assert (if_id_o.valid && (if_id_o.pc == chk_pc))
        else stop_run(mismatch($sformatf("if_id pc %h expected %h", if_id_o.pc, chk_pc)));
      assert ((if_id_o.instr == exp_instr) && (if_id_o.bus_err == mem_err(chk_pc))
              && (if_id_o.compressed == (exp_instr[1:0] != 2'b11)))
        else stop_run(mismatch($sformatf("if_id payload wrong at pc %h", chk_pc)));
      delivered = delivered + 1;
    end else if (last_ready) begin
      assert (!if_id_o.valid)
        else stop_run(mismatch("if_id valid without an accepted instruction"));
    end
    if (started && !last_ready) begin
      assert (if_id_o === last_if_id)
        else stop_run(mismatch("if_id changed while ID was stalled"));
    end
    check_pending = 1'b0;
    if (ctrl_i.pc_set) begin
      // Redirect: stream restarts, everything in flight goes stale
      exp_pc   = ref_target(ctrl_i);
      started  = 1'b1;
      stale    = pend_addr.size();
      buffered = 0;
    end else begin
      if (instr_rvalid_i) begin
        if (stale > 0) begin
          stale = stale - 1;
        end else begin
          buffered = buffered + 1;
        end
      end
      // Kill is only issued behind a valid head
      if (ctrl_i.kill_if) begin
        exp_pc   = exp_pc + 32'd4;
        buffered = buffered - 1;
      end else if (if_valid_o && id_ready_i) begin
        chk_pc        = exp_pc;
        check_pending = 1'b1;
        exp_pc        = exp_pc + 32'd4;
        buffered      = buffered - 1;
      end
    end
    assert (pend_addr.size() + buffered <= `FETCH_FIFO_DEPTH)
      else stop_run(mismatch($sformatf("%0d requests in flight plus %0d buffered",
                                       pend_addr.size(), buffered)));
    // Trap register shadow updates after the target is taken
    if (ctrl_i.pc_set && (ctrl_i.pc_mux == fetch_pkg::PC_BOOT)) begin
      sh_mtvec = boot_addr_i[31:7];
    end else if (csr_wr_i.we && (csr_wr_i.sel == fetch_pkg::CSR_MTVEC)) begin
      sh_mtvec = csr_wr_i.wdata[31:7];
    end
    if (csr_wr_i.we && (csr_wr_i.sel == fetch_pkg::CSR_MEPC)) begin
      sh_mepc = csr_wr_i.wdata;
    end
    last_ready = id_ready_i;
    last_if_id = if_id_o;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic drive_redirect(input fetch_pkg::pc_mux_e mux, input fetch_pkg::irq_id_t irq);
    next_cycle();
    ctrl_i.pc_set  = 1'b1;
    ctrl_i.pc_mux  = mux;
    ctrl_i.irq_id  = irq;
    ctrl_i.kill_if = 1'b1;
    next_cycle();
    ctrl_i.pc_set  = 1'b0;
    ctrl_i.kill_if = 1'b0;
  endtask

  task automatic csr_write(input fetch_pkg::csr_sel_e sel, input fetch_pkg::addr_t data);
    next_cycle();
    csr_wr_i = '{we: 1'b1, sel: sel, wdata: data};
    next_cycle();
    csr_wr_i.we = 1'b0;
  endtask

  task automatic wait_entries(input int n);
    int target;
    int cnt;
    target = delivered + n;
    cnt    = 0;
    while (delivered < target) begin
      @(negedge clk);
      cnt = cnt + 1;
      if (cnt > WAIT_CYCLES) begin
        stop_run("Timed out waiting for instructions to reach IF/ID");
      end
    end
  endtask

  // Wait until a granted fetch is still pending past the next cycle
  task automatic wait_outstanding();
    int cnt;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt = cnt + 1;
      if (cnt > WAIT_CYCLES) begin
        stop_run("Timed out waiting for an outstanding fetch");
      end
    end while (!((pend_due.size() > 0) && (pend_due[$] > cycle_cnt + 1)));
  endtask

  task automatic kill_head();
    int cnt;
    next_cycle();
    id_ready_i = 1'b0;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt = cnt + 1;
      if (cnt > WAIT_CYCLES) begin
        stop_run("Timed out waiting for a valid head to kill");
      end
    end while (!if_valid_o);
    next_cycle();
    ctrl_i.kill_if = 1'b1;
    next_cycle();
    ctrl_i.kill_if = 1'b0;
    id_ready_i     = 1'b1;
    wait_entries(3);
  endtask

  ////////////////////////////////////////////////////////////
  // Test phases
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n           = 1'b0;
    ctrl_i          = '0;
    csr_wr_i        = '0;
    boot_addr_i     = 32'h0000_2002;
    jump_target_i   = 32'h0000_3000;
    branch_target_i = 32'h0000_4100;
    id_ready_i      = 1'b0;
    instr_gnt_i     = 1'b0;
    instr_rvalid_i  = 1'b0;
    instr_rdata_i   = '0;
    instr_err_i     = 1'b0;
    repeat (3) @(posedge clk);
    #10;
    rst_n = 1'b1;
    // Idle window, nothing may fetch
    repeat (5) next_cycle();
    id_ready_i = 1'b1;
    repeat (3) next_cycle();
    // Boot stream runs through the error window
    drive_redirect(fetch_pkg::PC_BOOT, '0);
    wait_entries(24);
    // Redirects with fetches in flight
    wait_outstanding();
    drive_redirect(fetch_pkg::PC_JUMP, '0);
    wait_entries(6);
    wait_outstanding();
    drive_redirect(fetch_pkg::PC_BRANCH, '0);
    wait_entries(6);
    // Trap targets
    csr_write(fetch_pkg::CSR_MTVEC, 32'h8000_0180);
    csr_write(fetch_pkg::CSR_MEPC, 32'h0000_5006);
    drive_redirect(fetch_pkg::PC_TRAP_EXC, '0);
    wait_entries(3);
    stim_seed = lcg_next(stim_seed);
    drive_redirect(fetch_pkg::PC_TRAP_IRQ, stim_seed[20:16]);
    wait_entries(3);
    drive_redirect(fetch_pkg::PC_MRET, '0);
    wait_entries(3);
    next_cycle();
    boot_addr_i = 32'h0000_6F84;
    drive_redirect(fetch_pkg::PC_BOOT, '0);
    wait_entries(3);
    drive_redirect(fetch_pkg::PC_TRAP_EXC, '0);
    wait_entries(3);
    // Random back-pressure and halt
    for (int i = 0; i < 200; i++) begin
      next_cycle();
      stim_seed      = lcg_next(stim_seed);
      id_ready_i     = stim_seed[30];
      ctrl_i.halt_if = (stim_seed[29:27] == 3'b000);
    end
    next_cycle();
    id_ready_i     = 1'b1;
    ctrl_i.halt_if = 1'b0;
    wait_entries(4);
    // Kill drops only the head
    kill_head();
    kill_head();
    repeat (4) next_cycle();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire
